// ==== sources.f ====
+incdir+verification
verilog/arith_pkg.sv
verilog/queue_pkg.sv
verilog/sync_fifo.sv
verilog/div_core.sv
verilog/div_unit.sv
verification/div_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the div_unit testbench with Verilator.
# Pass or fail is taken from the simulation log.

cd "$(dirname "$0")" || exit 1

top=div_unit_tb
log=sim.log

verilator --binary --timing --assert \
    --top-module "$top" \
    -f sources.f \
    -o "$top"
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

if [ ! -x "./obj_dir/$top" ]; then
    echo "simulation executable not found"
    exit 1
fi

"./obj_dir/$top" > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TESTS PASSED" "$log"; then
    echo "run_sim: simulation passed"
    exit 0
else
    echo "run_sim: pass message not found in $log"
    exit 1
fi

// ==== verification/div_tests.svh ====
// every task starts and ends on a rising clock edge.
task automatic send_cmd(input word_t a, input word_t b, input logic s);
    in_valid <= 1'b1;
    in_dividend <= a;
    in_divisor <= b;
    in_signed <= s;
    @(posedge clk);
    while (!in_ready) @(posedge clk);
    in_valid <= 1'b0;
endtask

task automatic wait_drain();
    @(negedge clk);
    while (exp_q.size() != 0 || out_valid) @(negedge clk);
    @(posedge clk);
endtask

task automatic test_reset_state();
    @(negedge clk);
    assert (!out_valid) else fail_now("out_valid is high after reset");
    assert (in_ready) else fail_now("in_ready is low after reset");
    @(posedge clk);
endtask

task automatic test_unsigned();
    send_cmd(16'd100, 16'd7, 1'b0);
    send_cmd(16'd7, 16'd100, 1'b0);     // dividend below divisor.
    send_cmd(16'hFFFF, 16'hFFFF, 1'b0);
    send_cmd(16'hFFFF, 16'd1, 1'b0);
    send_cmd(16'hFFFF, 16'h00FF, 1'b0);
    send_cmd(16'h8000, 16'd3, 1'b0);
    send_cmd(16'd0, 16'd5, 1'b0);
    wait_drain();
endtask

task automatic test_signed();
    send_cmd(16'd100, 16'd7, 1'b1);
    send_cmd(-16'd100, 16'd7, 1'b1);
    send_cmd(16'd100, -16'd7, 1'b1);
    send_cmd(-16'd100, -16'd7, 1'b1);
    send_cmd(16'h8000, 16'd1, 1'b1);    // most negative dividend.
    send_cmd(-16'd1, 16'h7FFF, 1'b1);
    wait_drain();
endtask

task automatic test_div_by_zero();
    send_cmd(16'd1234, 16'd0, 1'b0);
    send_cmd(-16'd1234, 16'd0, 1'b1);
    wait_drain();
endtask

task automatic test_back_pressure();
    int accepted;
    int idle;
    accepted = 0;
    idle = 0;
    out_ready <= 1'b0;
    in_valid <= 1'b1;
    in_dividend <= word_t'($urandom);
    in_divisor <= word_t'($urandom_range(1, 255));
    in_signed <= 1'($urandom_range(0, 1));
    // keep offering until the whole chain has stalled.
    while (idle < 2 * (data_width + 4)) begin
        @(posedge clk);
        if (in_ready) begin
            accepted++;
            idle = 0;
            in_dividend <= word_t'($urandom);
            in_divisor <= word_t'($urandom_range(1, 255));
            in_signed <= 1'($urandom_range(0, 1));
        end else begin
            idle++;
        end
    end
    in_valid <= 1'b0;
    assert (accepted == max_in_flight) else
        fail_now($sformatf("back-pressure accepted %0d commands, expected %0d",
                           accepted, max_in_flight));
    out_ready <= 1'b1;
    wait_drain();
endtask

task automatic test_random_stream();
    word_t b;
    random_ready <= 1'b1;
    for (int i = 0; i < 200; i++) begin
        b = word_t'($urandom);
        if ($urandom_range(0, 3) == 0) begin
            b = b >> 10;                // small divisors give wide quotients.
        end
        send_cmd(word_t'($urandom), b, 1'($urandom_range(0, 1)));
    end
    random_ready <= 1'b0;
    @(posedge clk);
    out_ready <= 1'b1;
    wait_drain();
endtask

// ==== verification/div_unit_tb.sv ====
module div_unit_tb
    import arith_pkg::*;
    import queue_pkg::*;
();

    localparam int total_cmds = 224;
    localparam int timeout_cycles = total_cmds * (data_width + 4) + 400;
    localparam int max_in_flight = cmd_depth + 1 + res_depth;

    logic  clk;
    logic  rst;
    logic  in_valid;
    logic  in_ready;
    word_t in_dividend;
    word_t in_divisor;
    logic  in_signed;
    logic  out_valid;
    logic  out_ready;
    word_t out_quotient;
    word_t out_remainder;
    logic  out_div_by_zero;

    logic random_ready;      // lets out_ready toggle randomly.
    div_res_t exp_q[$];
    int cycles = 0;

    div_unit u_div_unit (
        .clk(clk),
        .rst(rst),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .in_dividend(in_dividend),
        .in_divisor(in_divisor),
        .in_signed(in_signed),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_quotient(out_quotient),
        .out_remainder(out_remainder),
        .out_div_by_zero(out_div_by_zero)
    );

    always #20 clk = ~clk;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        assert (actual == expected) else
            fail_now($sformatf("FAIL %s expected 0x%h got 0x%h", name, expected, actual));
    endtask

    // truncating division with the remainder taking the sign of the dividend.
    function automatic div_res_t expected_result(input word_t a, input word_t b, input logic s);
        div_res_t r;
        int sa;
        int sb;
        if (b == '0) begin
            r.quotient = '1;
            r.remainder = a;
            r.div_by_zero = 1'b1;
            return r;
        end
        sa = s ? int'(signed'(a)) : int'(a);
        sb = s ? int'(signed'(b)) : int'(b);
        r.quotient = word_t'(sa / sb);
        r.remainder = word_t'(sa % sb);
        r.div_by_zero = 1'b0;
        return r;
    endfunction

    // expected results queue up in command order.
    always @(posedge clk) begin
        div_res_t expected;
        if (!rst) begin
            if (in_valid && in_ready) begin
                exp_q.push_back(expected_result(in_dividend, in_divisor, in_signed));
            end
            if (out_valid && out_ready) begin
                assert (exp_q.size() != 0) else
                    fail_now("a result came out with no command outstanding");
                expected = exp_q.pop_front();
                check_value("out_quotient", expected.quotient, out_quotient);
                check_value("out_remainder", expected.remainder, out_remainder);
                check_value("out_div_by_zero", word_t'(expected.div_by_zero),
                            word_t'(out_div_by_zero));
            end
        end
    end

    always @(posedge clk) begin
        if (random_ready) begin
            out_ready <= 1'($urandom_range(0, 1));
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            fail_now($sformatf("timeout: the run did not end within %0d cycles", timeout_cycles));
        end
    end

    `include "div_tests.svh"

    initial begin
        void'($urandom(58420));
        clk = 1'b0;
        rst = 1'b1;
        in_valid = 1'b0;
        in_dividend = '0;
        in_divisor = '0;
        in_signed = 1'b0;
        out_ready = 1'b1;
        random_ready = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        test_reset_state();
        test_unsigned();
        test_signed();
        test_div_by_zero();
        test_back_pressure();
        test_random_stream();
        if (exp_q.size() == 0 && !out_valid) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            fail_now("results were still outstanding at the end of the run");
        end
    end

endmodule

// ==== verilog/div_unit.sv ====
module div_unit
    import arith_pkg::*;
    import queue_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  in_valid,
    output logic  in_ready,
    input  word_t in_dividend,
    input  word_t in_divisor,
    input  logic  in_signed,
    output logic  out_valid,
    input  logic  out_ready,
    output word_t out_quotient,
    output word_t out_remainder,
    output logic  out_div_by_zero
);

    div_cmd_t in_cmd;
    div_res_t out_res;

    logic cmd_valid;
    logic cmd_ready;
    div_cmd_t cmd;

    logic res_valid;
    logic res_ready;
    div_res_t res;

    assign in_cmd = '{dividend: in_dividend, divisor: in_divisor, is_signed: in_signed};

    sync_fifo #(
        .payload_t(div_cmd_t),
        .depth(cmd_depth)
    ) u_cmd_queue (
        .clk(clk),
        .rst(rst),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .in_data(in_cmd),
        .out_valid(cmd_valid),
        .out_ready(cmd_ready),
        .out_data(cmd)
    );

    div_core u_core (
        .clk(clk),
        .rst(rst),
        .cmd_valid(cmd_valid),
        .cmd_ready(cmd_ready),
        .cmd(cmd),
        .res_valid(res_valid),
        .res_ready(res_ready),
        .res(res)
    );

    // results leave in command order since the core handles one at a time.
    sync_fifo #(
        .payload_t(div_res_t),
        .depth(res_depth)
    ) u_res_queue (
        .clk(clk),
        .rst(rst),
        .in_valid(res_valid),
        .in_ready(res_ready),
        .in_data(res),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_data(out_res)
    );

    assign out_quotient = out_res.quotient;
    assign out_remainder = out_res.remainder;
    assign out_div_by_zero = out_res.div_by_zero;

endmodule

// ==== verilog/div_core.sv ====
module div_core import arith_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     cmd_valid,
    output logic     cmd_ready,
    input  div_cmd_t cmd,
    output logic     res_valid,
    input  logic     res_ready,
    output div_res_t res
);

    typedef enum logic [1:0] {
        s_idle,
        s_busy,
        s_done
    } state_t;

    state_t state;
    logic [count_width-1:0] count;

    // remainder in the upper half while the quotient shifts into the lower half.
    logic [2*data_width-1:0] part;
    word_t divisor_mag;
    word_t dividend_q;
    logic neg_dividend;
    logic neg_quotient;
    logic zero_div;

    logic neg_a;
    logic neg_b;
    word_t abs_a;
    word_t abs_b;
    logic [data_width:0] partial;
    logic [data_width+1:0] diff;
    word_t quot_mag;
    word_t rem_mag;

    // sign pre-correction on the incoming command.
    assign neg_a = cmd.is_signed && cmd.dividend[data_width-1];
    assign neg_b = cmd.is_signed && cmd.divisor[data_width-1];
    assign abs_a = neg_a ? -cmd.dividend : cmd.dividend;
    assign abs_b = neg_b ? -cmd.divisor : cmd.divisor;

    // trial subtract of the shifted partial remainder with the borrow in the top bit.
    assign partial = part[2*data_width-1:data_width-1];
    assign diff = {1'b0, partial} - {2'b00, divisor_mag};

    assign quot_mag = part[data_width-1:0];
    assign rem_mag = part[2*data_width-1:data_width];

    assign cmd_ready = state == s_idle;
    assign res_valid = state == s_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_idle;
            count <= '0;
        end else begin
            case (state)
                s_idle: begin
                    if (cmd_valid) begin
                        state <= s_busy;
                        count <= count_width'(data_width);
                    end
                end
                s_busy: begin
                    count <= count - 1'b1;
                    if (count == count_width'(1)) begin
                        state <= s_done;   // last quotient bit this cycle.
                    end
                end
                s_done: begin
                    if (res_ready) begin
                        state <= s_idle;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) begin
            part <= {{data_width{1'b0}}, abs_a};
            divisor_mag <= abs_b;
            dividend_q <= cmd.dividend;
            neg_dividend <= neg_a;
            neg_quotient <= neg_a ^ neg_b;
            zero_div <= cmd.divisor == '0;
        end else if (state == s_busy) begin
            if (diff[data_width+1]) begin
                part <= {part[2*data_width-2:0], 1'b0};
            end else begin
                part <= {diff[data_width-1:0], part[data_width-2:0], 1'b1};
            end
        end
    end

    // sign post-correction where the remainder follows the dividend.
    always_comb begin
        res.div_by_zero = zero_div;
        if (zero_div) begin
            res.quotient = '1;
            res.remainder = dividend_q;
        end else begin
            res.quotient = neg_quotient ? -quot_mag : quot_mag;
            res.remainder = neg_dividend ? -rem_mag : rem_mag;
        end
    end

    // a result is only offered once all iterations have run.
    iter_done: assert property (
        @(posedge clk) disable iff (rst) res_valid |-> count == '0
    ) else $error("div_core: result offered before the last iteration");

endmodule

// ==== verilog/sync_fifo.sv ====
module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
    localparam int occ_width = $clog2(depth + 1);

    payload_t mem [depth];
    logic [ptr_width-1:0] rd_ptr;
    logic [ptr_width-1:0] wr_ptr;
    logic [occ_width-1:0] count;
    logic do_write;
    logic do_read;

    // wraps at depth, so non power of two depths also work.
    function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
        if (ptr == ptr_width'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign in_ready = count < occ_width'(depth);
    assign out_valid = count != '0;
    assign out_data = mem[rd_ptr];   // show-ahead read.

    assign do_write = in_valid && in_ready;
    assign do_read = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_read) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_write, do_read})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= in_data;
        end
    end

    occupancy_bound: assert property (
        @(posedge clk) disable iff (rst) count <= occ_width'(depth)
    ) else $error("sync_fifo: occupancy above depth");

    // a stalled head entry must not move until it is taken.
    head_stable: assert property (
        @(posedge clk) disable iff (rst) out_valid && !out_ready |=> $stable(out_data)
    ) else $error("sync_fifo: head entry changed while stalled");

endmodule

// ==== verilog/queue_pkg.sv ====
package queue_pkg;

    // entries waiting in front of the divider core.
    localparam int cmd_depth = 4;

    // results waiting for the consumer.
    localparam int res_depth = 4;

endpackage

// ==== verilog/arith_pkg.sv ====
package arith_pkg;

    // operand and result width.
    localparam int data_width = 16;

    // iteration counter, wide enough to hold data_width.
    localparam int count_width = 5;

    typedef logic [data_width-1:0] word_t;

    // one division request as it sits in the command queue.
    typedef struct packed {
        word_t dividend;
        word_t divisor;
        logic  is_signed;   // two's complement operands when set.
    } div_cmd_t;

    // one division result as it sits in the result queue.
    typedef struct packed {
        word_t quotient;
        word_t remainder;
        logic  div_by_zero;
    } div_res_t;

endpackage
